/* Makefile */
SIM = obj_dir/sim_fetch

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_fetch -f all.f -o sim_fetch

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
source/cpu_pkg.sv
source/instr_decoder.sv
source/instr_cache.sv
source/if_id_stage.sv
source/ex_stage.sv
source/fetch_top.sv
tests/fetch_checker.sv
tests/tb_fetch.sv

/* source/cpu_pkg.sv */
package cpu_pkg;

	// byte address width on the fetch side
	localparam int ADDR_W = 16;

	// one instruction is one 32-bit word
	localparam int INSTR_W = 32;

	// pc step per instruction
	localparam int INSTR_BYTES = INSTR_W / 8;

	localparam int REG_IDX_W = 4;
	localparam int OPER_W = 4;
	localparam int IMM_W = 13;

	// jump offset, signed count of instructions
	localparam int OFFSET_W = 25;

	// instruction groups, top two bits of the word
	localparam logic [1:0] GROUP_ALU = 2'd0;
	localparam logic [1:0] GROUP_CTRL = 2'd1;
	localparam logic [1:0] GROUP_LOAD = 2'd2;
	localparam logic [1:0] GROUP_STORE = 2'd3;

	// control-flow opers
	localparam logic [OPER_W-1:0] CTRL_REL = 4'd0;
	localparam logic [OPER_W-1:0] CTRL_ABS = 4'd1;

	// register format
	typedef struct packed {
		logic [1:0] group;
		logic [OPER_W-1:0] oper;
		logic nop;
		logic [REG_IDX_W-1:0] ra;
		logic [REG_IDX_W-1:0] rb;
		logic [REG_IDX_W-1:0] rc;
		logic [IMM_W-1:0] imm;
	} instr_reg_t;

	// control-flow format, offset sits on the index bits
	typedef struct packed {
		logic [1:0] group;
		logic [OPER_W-1:0] oper;
		logic nop;
		logic signed [OFFSET_W-1:0] offset;
	} instr_ctrl_t;

	// one fetched word, read either way
	typedef union packed {
		instr_reg_t reg_fmt;
		instr_ctrl_t ctrl_fmt;
		logic [INSTR_W-1:0] raw;
	} instr_word_u;

	// what travels from IF/ID to EX; all zero is a bubble
	typedef struct packed {
		logic [1:0] group;
		logic [OPER_W-1:0] oper;
		logic nop;
		logic [REG_IDX_W-1:0] ra;
		logic [REG_IDX_W-1:0] rb;
		logic [REG_IDX_W-1:0] rc;
		logic signed [OFFSET_W-1:0] offset;
	} decoded_t;

endpackage

/* source/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage #(
	parameter int LDST_CYCLES = 4
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input cpu_pkg::decoded_t ex_decoded,
	input logic [cpu_pkg::ADDR_W-1:0] ex_pc,
	output logic [cpu_pkg::ADDR_W-1:0] computed_pc,
	output logic wb_stall,
	output logic issue_valid,
	output logic [cpu_pkg::ADDR_W-1:0] issue_pc,
	output logic [1:0] issue_group,
	output logic [cpu_pkg::OPER_W-1:0] issue_oper,
	output logic [cpu_pkg::REG_IDX_W-1:0] issue_ra,
	output logic [cpu_pkg::REG_IDX_W-1:0] issue_rb,
	output logic [cpu_pkg::REG_IDX_W-1:0] issue_rc
);

	localparam int CNT_W = $clog2(LDST_CYCLES + 1);

	// remaining memory-port cycles
	logic [CNT_W-1:0] busy_cnt;

	logic is_bubble;
	logic accept;
	logic is_ldst;

	// offset in bytes, wraps to the address width
	logic [cpu_pkg::ADDR_W-1:0] offset_bytes;

	assign is_bubble = (ex_decoded == '0);
	assign accept = ~hold & ~is_bubble;
	assign is_ldst = (ex_decoded.group == cpu_pkg::GROUP_LOAD)
		| (ex_decoded.group == cpu_pkg::GROUP_STORE);
	assign offset_bytes = {ex_decoded.offset[cpu_pkg::ADDR_W-3:0], 2'b00};
	assign wb_stall = (busy_cnt != '0);

	// branch target, ex_pc already points past the jump
	always_comb
	begin
		if (ex_decoded.group != cpu_pkg::GROUP_CTRL)
			computed_pc = ex_pc;
		else if (ex_decoded.oper == cpu_pkg::CTRL_ABS)
			computed_pc = offset_bytes;
		else
			computed_pc = ex_pc + offset_bytes;
	end

	// issue report payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			issue_pc <= ex_pc;
			issue_group <= ex_decoded.group;
			issue_oper <= ex_decoded.oper;
			issue_ra <= ex_decoded.ra;
			issue_rb <= ex_decoded.rb;
			issue_rc <= ex_decoded.rc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			issue_valid <= 1'b0;
			busy_cnt <= '0;
		end
		else
		begin
			// one-cycle strobe per accepted instruction
			issue_valid <= accept;
			if (accept && is_ldst)
				busy_cnt <= CNT_W'(LDST_CYCLES);
			else if (busy_cnt != '0)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

endmodule

/* source/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top #(
	parameter int LINES = 8,
	parameter int MISS_CYCLES = 3,
	parameter int LDST_CYCLES = 4
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic load_en,
	input logic [cpu_pkg::ADDR_W-1:0] load_addr,
	input logic [cpu_pkg::INSTR_W-1:0] load_data,
	output logic issue_valid,
	output logic [cpu_pkg::ADDR_W-1:0] issue_pc,
	output logic [1:0] issue_group,
	output logic [cpu_pkg::OPER_W-1:0] issue_oper,
	output logic [cpu_pkg::REG_IDX_W-1:0] issue_ra,
	output logic [cpu_pkg::REG_IDX_W-1:0] issue_rb,
	output logic [cpu_pkg::REG_IDX_W-1:0] issue_rc,
	output logic mem_busy
);

	// stage to cache
	logic fetch_req;
	logic [cpu_pkg::ADDR_W-1:0] fetch_addr;

	// cache to stage
	logic resp_valid;
	logic [cpu_pkg::INSTR_W-1:0] resp_instr;

	// stage to EX and back
	cpu_pkg::decoded_t ex_decoded;
	logic [cpu_pkg::ADDR_W-1:0] ex_pc;
	logic [cpu_pkg::ADDR_W-1:0] computed_pc;
	logic wb_stall;

	// memory port busy is the write-back stall
	assign mem_busy = wb_stall;

	instr_cache #(
		.LINES(LINES),
		.MISS_CYCLES(MISS_CYCLES)
	) u_cache (
		.clk(clk),
		.rst(rst),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.resp_valid(resp_valid),
		.resp_instr(resp_instr),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

	if_id_stage u_if_id (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.resp_valid(resp_valid),
		.resp_instr(resp_instr),
		.computed_pc(computed_pc),
		.wb_stall(wb_stall),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.ex_decoded(ex_decoded),
		.ex_pc(ex_pc)
	);

	ex_stage #(
		.LDST_CYCLES(LDST_CYCLES)
	) u_ex (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.ex_decoded(ex_decoded),
		.ex_pc(ex_pc),
		.computed_pc(computed_pc),
		.wb_stall(wb_stall),
		.issue_valid(issue_valid),
		.issue_pc(issue_pc),
		.issue_group(issue_group),
		.issue_oper(issue_oper),
		.issue_ra(issue_ra),
		.issue_rb(issue_rb),
		.issue_rc(issue_rc)
	);

endmodule

/* source/if_id_stage.sv */
`timescale 1ns/10ps

module if_id_stage (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic resp_valid,
	input logic [cpu_pkg::INSTR_W-1:0] resp_instr,
	input logic [cpu_pkg::ADDR_W-1:0] computed_pc,
	input logic wb_stall,
	output logic fetch_req,
	output logic [cpu_pkg::ADDR_W-1:0] fetch_addr,
	output cpu_pkg::decoded_t ex_decoded,
	output logic [cpu_pkg::ADDR_W-1:0] ex_pc
);

	localparam logic [2:0] ST_INIT = 3'd0;
	localparam logic [2:0] ST_REGULAR = 3'd1;
	localparam logic [2:0] ST_CHANGE_PC = 3'd2;
	localparam logic [2:0] ST_WAIT_LDST0 = 3'd3;
	localparam logic [2:0] ST_WAIT_LDST1 = 3'd4;

	logic [2:0] state;

	// speculative pc, address of the word the cache is answering for
	logic [cpu_pkg::ADDR_W-1:0] spec_pc;
	logic [cpu_pkg::ADDR_W-1:0] following_pc;

	// fetching starts on the first cycle out of reset
	logic fetch_on;

	cpu_pkg::decoded_t dec;
	logic changes_pc;

	instr_decoder u_decoder (
		.instr(resp_instr),
		.decoded(dec)
	);

	assign following_pc = spec_pc + cpu_pkg::ADDR_W'(cpu_pkg::INSTR_BYTES);
	assign changes_pc = (dec.group == cpu_pkg::GROUP_CTRL) & ~dec.nop;
	assign fetch_req = fetch_on;

	// fetch address choice
	always_comb
	begin
		case (state)
		ST_REGULAR:
		begin
			// stay put unless the current word is consumed and falls through
			if (!resp_valid || hold || changes_pc)
				fetch_addr = spec_pc;
			else
				fetch_addr = following_pc;
		end
		ST_CHANGE_PC:
			fetch_addr = computed_pc;
		default:
			fetch_addr = spec_pc;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			fetch_on <= 1'b0;
		else
			fetch_on <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_INIT;
			spec_pc <= '0;
			ex_decoded <= '0;
			ex_pc <= '0;
		end
		// hold freezes state and outputs in every state
		else if (!hold)
		begin
			case (state)
			ST_INIT:
			begin
				// first answer from the cache
				if (resp_valid)
					state <= ST_REGULAR;
				ex_decoded <= '0;
			end

			ST_REGULAR:
			begin
				if (!resp_valid)
					ex_decoded <= '0;
				else
				begin
					spec_pc <= following_pc;
					if (dec.nop)
						ex_decoded <= '0;
					else
					begin
						ex_decoded <= dec;
						case (dec.group)
						cpu_pkg::GROUP_ALU:
							ex_pc <= spec_pc;
						cpu_pkg::GROUP_CTRL:
						begin
							// EX computes targets from the following pc
							ex_pc <= following_pc;
							state <= ST_CHANGE_PC;
						end
						default:
						begin
							// load or store
							ex_pc <= spec_pc;
							state <= ST_WAIT_LDST0;
						end
						endcase
					end
				end
			end

			ST_CHANGE_PC:
			begin
				// target ready while the jump sits in EX
				spec_pc <= computed_pc;
				state <= ST_REGULAR;
				ex_decoded <= '0;
			end

			ST_WAIT_LDST0:
			begin
				// EX loads its busy counter this cycle
				state <= ST_WAIT_LDST1;
				ex_decoded <= '0;
			end

			ST_WAIT_LDST1:
			begin
				if (!wb_stall)
					state <= ST_REGULAR;
				ex_decoded <= '0;
			end

			default:
			begin
				state <= ST_INIT;
				ex_decoded <= '0;
			end
			endcase
		end
	end

endmodule

/* source/instr_cache.sv */
`timescale 1ns/10ps

module instr_cache #(
	parameter int LINES = 8,
	parameter int MISS_CYCLES = 3
) (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input logic [cpu_pkg::ADDR_W-1:0] fetch_addr,
	output logic resp_valid,
	output logic [cpu_pkg::INSTR_W-1:0] resp_instr,
	input logic load_en,
	input logic [cpu_pkg::ADDR_W-1:0] load_addr,
	input logic [cpu_pkg::INSTR_W-1:0] load_data
);

	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = cpu_pkg::ADDR_W - 2 - IDX_W;
	localparam int CNT_W = $clog2(MISS_CYCLES + 1);

	// backing store, written only through the load port
	logic [cpu_pkg::INSTR_W-1:0] backing [MEM_WORDS];

	// direct-mapped lines
	logic [cpu_pkg::INSTR_W-1:0] line_data [LINES];
	logic [TAG_W-1:0] line_tag [LINES];
	logic [LINES-1:0] line_valid;

	// outstanding miss
	logic pend;
	logic [cpu_pkg::ADDR_W-1:0] pend_addr;
	logic [CNT_W-1:0] miss_cnt;

	logic lookup;
	logic hit;
	logic fill;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [MEM_IDX_W-1:0] mem_idx;

	// word address split into index and tag
	assign idx = fetch_addr[IDX_W+1:2];
	assign tag = fetch_addr[cpu_pkg::ADDR_W-1:IDX_W+2];
	assign mem_idx = fetch_addr[MEM_IDX_W+1:2];

	assign lookup = fetch_req & ~load_en;
	assign hit = lookup & line_valid[idx] & (line_tag[idx] == tag);

	// countdown done on the same address
	assign fill = lookup & ~hit & pend & (pend_addr == fetch_addr) & (miss_cnt == '0);

	always_ff @(posedge clk)
	begin
		if (load_en)
			backing[load_addr[MEM_IDX_W+1:2]] <= load_data;
	end

	// line and response payload
	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			line_data[idx] <= backing[mem_idx];
			line_tag[idx] <= tag;
			resp_instr <= backing[mem_idx];
		end
		else if (hit)
			resp_instr <= line_data[idx];
	end

	always_ff @(posedge clk)
	begin
		if (rst || load_en)
		begin
			// new program, every line stale
			line_valid <= '0;
			pend <= 1'b0;
			resp_valid <= 1'b0;
		end
		else
		begin
			resp_valid <= hit | fill;
			if (hit)
				pend <= 1'b0;
			else if (fill)
			begin
				pend <= 1'b0;
				line_valid[idx] <= 1'b1;
			end
			else if (lookup && pend && pend_addr == fetch_addr)
				miss_cnt <= miss_cnt - 1'b1;
			else if (lookup)
			begin
				// fresh miss, also drops a fill for another address
				pend <= 1'b1;
				pend_addr <= fetch_addr;
				miss_cnt <= CNT_W'(MISS_CYCLES - 1);
			end
		end
	end

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
	input logic [cpu_pkg::INSTR_W-1:0] instr,
	output cpu_pkg::decoded_t decoded
);

	// same word, two views
	cpu_pkg::instr_word_u word;

	// all-zero word is treated like a nop
	logic is_zero;

	assign word.raw = instr;
	assign is_zero = (instr == '0);

	always_comb
	begin
		// common header, identical in both formats
		decoded.group = word.reg_fmt.group;
		decoded.oper = word.reg_fmt.oper;

		// explicit nop bit or empty word
		decoded.nop = word.reg_fmt.nop | is_zero;

		// register indices from the register view
		decoded.ra = word.reg_fmt.ra;
		decoded.rb = word.reg_fmt.rb;
		decoded.rc = word.reg_fmt.rc;

		// offset from the control view
		// only meaningful for the ctrl group
		decoded.offset = word.ctrl_fmt.offset;
	end

endmodule

/* tests/fetch_checker.sv */
`timescale 1ns/10ps

module fetch_checker (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic wb_stall,
	input logic [cpu_pkg::ADDR_W-1:0] fetch_addr,
	input cpu_pkg::decoded_t ex_decoded,
	input logic [cpu_pkg::ADDR_W-1:0] ex_pc
);

	// jump leaving the stage this cycle
	logic ctrl_sent;

	assign ctrl_sent = (ex_decoded.group == cpu_pkg::GROUP_CTRL);

	// back-pressure freezes the registered outputs
	hold_freezes_outputs: assert property (@(posedge clk) disable iff (rst)
		hold |=> (ex_decoded == $past(ex_decoded)) && (ex_pc == $past(ex_pc)))
	else
		$error("stage outputs moved while hold was high");

	// fetch address held across a hold period
	hold_freezes_fetch: assert property (@(posedge clk) disable iff (rst)
		(hold && $past(hold)) |-> $stable(fetch_addr))
	else
		$error("fetch address moved while hold was high");

	// jump always followed by a bubble
	bubble_after_jump: assert property (@(posedge clk) disable iff (rst)
		(ctrl_sent && !hold) |=> (ex_decoded == '0))
	else
		$error("no bubble after a control-flow instruction");

	// only bubbles go out while the memory port is busy
	quiet_while_busy: assert property (@(posedge clk) disable iff (rst)
		(wb_stall && !hold) |=> (ex_decoded == '0))
	else
		$error("instruction sent while the memory port was busy");

endmodule

bind if_id_stage fetch_checker u_checker (
	.clk(clk),
	.rst(rst),
	.hold(hold),
	.wb_stall(wb_stall),
	.fetch_addr(fetch_addr),
	.ex_decoded(ex_decoded),
	.ex_pc(ex_pc)
);

/* tests/fetch_vectors.txt */
// header 7E57_HHNN: HH=01 random hold, NN program words; then NN words from address 0
// expected issues PP0G_ORBC: PP pc word index, G group, O oper, R/B/C ra rb rc; FFFFFFFF ends a test
// straight-line alu
7E57_0005
04246000 088AC000 0CF12000 01FDA000 41FFFFFF
00001123 01002456 02003789 03000FED 05010FFF
FFFFFFFF
// nop and zero words skipped
7E57_0008
04246000 02000000 00000000 088AC000 0E246000 42000005 0CF12000 41FFFFFF
00001123 03002456 06003789 08010FFF
FFFFFFFF
// relative and absolute jumps
7E57_000B
04246000 40000002 088AC000 0CF12000 01FDA000 44000009
04246000 088AC000 088AC000 088AC000 41FFFFFF
00001123 02010000 04000FED 06011000 09002456 0B010FFF
FFFFFFFF
// load and store busy periods
7E57_0006
04246000 94246000 088AC000 D8F12000 0CF12000 41FFFFFF
00001123 01025123 02002456 03036789 04003789 06010FFF
FFFFFFFF
// mixed program under random hold
7E57_0108
04246000 94246000 02000000 40000001 0CF12000 D8F12000 088AC000 41FFFFFF
00001123 01025123 04010000 05036789 06002456 08010FFF
FFFFFFFF
// loop run twice, misses then hits
7E57_0003
04246000 088AC000 41FFFFFD
00001123 01002456 03010FFF 00001123 01002456 03010FFF
FFFFFFFF
00000000

/* tests/tb_fetch.sv */
`timescale 1ns/10ps

module tb_fetch;

	localparam int VEC_DEPTH = 512;
	localparam int ISSUE_TIMEOUT = 400;

	logic clk;
	logic rst;
	logic hold;
	logic load_en;
	logic [cpu_pkg::ADDR_W-1:0] load_addr;
	logic [cpu_pkg::INSTR_W-1:0] load_data;
	logic issue_valid;
	logic [cpu_pkg::ADDR_W-1:0] issue_pc;
	logic [1:0] issue_group;
	logic [cpu_pkg::OPER_W-1:0] issue_oper;
	logic [cpu_pkg::REG_IDX_W-1:0] issue_ra;
	logic [cpu_pkg::REG_IDX_W-1:0] issue_rb;
	logic [cpu_pkg::REG_IDX_W-1:0] issue_rc;
	logic mem_busy;

	// headers, programs and expected issues
	logic [31:0] vec [VEC_DEPTH];
	logic [31:0] expect_q [$];

	logic random_hold;
	// memory port state seen on the previous sample
	logic prev_busy;
	int unsigned seed_val;

	fetch_top #(
		.LINES(8),
		.MISS_CYCLES(3),
		.LDST_CYCLES(4)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.issue_valid(issue_valid),
		.issue_pc(issue_pc),
		.issue_group(issue_group),
		.issue_oper(issue_oper),
		.issue_ra(issue_ra),
		.issue_rb(issue_rb),
		.issue_rc(issue_rc),
		.mem_busy(mem_busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// back-pressure about one cycle in three when enabled
	initial
	begin
		seed_val = $urandom(93);
		hold = 1'b0;
		forever
		begin
			@(posedge clk);
			if (rst || !random_hold)
				hold <= 1'b0;
			else
				hold <= (($urandom % 32'd3) == 32'd0);
		end
	end

	task automatic compare(input string name, input logic [33:0] expected,
		input logic [33:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	// wait for the next issue strobe on the falling edge
	task automatic wait_issue(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!issue_valid)
		begin
			prev_busy = mem_busy;
			cycles++;
			if (cycles > ISSUE_TIMEOUT)
				abort_run($sformatf("%s: no instruction issued within the timeout", name));
			@(negedge clk);
		end
		if (prev_busy)
			abort_run($sformatf("%s: issued while the memory port was busy", name));
		prev_busy = mem_busy;
	endtask

	initial
	begin
		int ptr;
		int prog_len;
		int test_no;
		logic [31:0] e;
		logic [33:0] want;
		logic [33:0] got;
		string name;

		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		random_hold = 1'b0;
		prev_busy = 1'b0;
		$readmemh("tests/fetch_vectors.txt", vec);

		ptr = 0;
		test_no = 0;
		while (vec[ptr][31:16] == 16'h7E57)
		begin
			prog_len = int'(vec[ptr][7:0]);
			@(posedge clk);
			rst <= 1'b1;
			random_hold <= vec[ptr][8];
			ptr++;
			// program goes in while the core is in reset
			for (int i = 0; i < prog_len; i++)
			begin
				@(posedge clk);
				load_en <= 1'b1;
				load_addr <= cpu_pkg::ADDR_W'(i * 4);
				load_data <= vec[ptr + i];
			end
			@(posedge clk);
			load_en <= 1'b0;
			repeat (10) @(posedge clk);
			ptr += prog_len;
			expect_q.delete();
			while (vec[ptr] != 32'hFFFF_FFFF)
			begin
				expect_q.push_back(vec[ptr]);
				ptr++;
			end
			ptr++;
			prev_busy = 1'b0;
			rst <= 1'b0;
			for (int k = 0; k < expect_q.size(); k++)
			begin
				name = $sformatf("test %0d issue %0d", test_no, k);
				e = expect_q[k];
				wait_issue(name);
				// pc column is a word index
				want = {6'b0, e[31:24], 2'b00, e[17:16], e[15:12], e[11:8], e[7:4], e[3:0]};
				got = {issue_pc, issue_group, issue_oper, issue_ra, issue_rb, issue_rc};
				compare(name, want, got);
				// busy count starts with the load or store issue
				if (e[17])
					compare({name, " busy"}, 34'd1, {33'd0, mem_busy});
			end
			test_no++;
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
